/* rv_core.f */
hdl/rv_pkg.sv
hdl/rv_alu.sv
hdl/rv_regfile.sv
hdl/rv_controller.sv
hdl/rv_hazard.sv
hdl/rv_datapath.sv
hdl/rv_core.sv
tb/rv_core_mem.sv
tb/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - hdl/rv_pkg.sv
  - hdl/rv_alu.sv
  - hdl/rv_regfile.sv
  - hdl/rv_controller.sv
  - hdl/rv_hazard.sv
  - hdl/rv_datapath.sv
  - hdl/rv_core.sv
  - target: test
    files:
      - tb/rv_core_mem.sv
      - tb/rv_core_tb.sv

/* tb/rv_core_patterns.hex */
// word 0 program length, word 1 check count, then program words
// then checks as: byte address, expected word, kind (test number, 1x = must stay unwritten)
0000004D 00000025
123450B7 06400113 FF900193 00310233 10402023 403102B3 10502223 0020E333
10602423 003343B3 10702623 0023F433 10802823 0021A4B3 10902A23 0021B533
10A02C23 002115B3 10B02E23 0091D633 12C02023 4091D6B3 12D02223 0F037713
12E02423 70016793 12F02623 FFF14813 13002823 FFA1A893 13102A23 03213913
13202C23 00811993 13302E23 01C1DA13 15402023 4011DA93 15502223 14102423
00210B33 016B0B33 002B0B33 15602623 10802B83 001B8C13 15802823 00948463
20102023 00310463 16902023 00311463 20102223 00949463 16202223 0021C463
20102423 00314463 16302423 00315463 20102623 0021D463 16402623 00316463
20102823 0021E463 16502823 0021F463 20102A23 00317463 16802A23 00C00CEF
20102C23 20102E23 17902C23 3E202E23 0000006F
// alu and immediate results
00000100 0000005D 02
00000104 0000006B 02
00000108 12345064 02
0000010C EDCBAF9D 02
00000110 00000004 02
00000114 00000001 02
00000118 00000000 02
0000011C 00000640 02
00000120 7FFFFFFC 02
00000124 FFFFFFFC 02
00000128 00000060 02
0000012C 00000764 02
00000130 FFFFFF9B 02
00000134 00000001 02
00000138 00000000 02
0000013C 00006400 02
00000140 0000000F 02
00000144 FFFFFFFC 02
00000148 12345000 02
// forwarding chain, load-use
0000014C 000001F4 03
00000150 12345065 04
// branches not taken, jal link
00000160 00000001 05
00000164 00000064 05
00000168 FFFFFFF9 05
0000016C 0000005D 05
00000170 0000006B 05
00000174 00000004 05
00000178 00000120 05
// closing store
000003FC 00000064 06
// skipped markers keep the ram fill
00000200 A5A50080 15
00000204 A5A50081 15
00000208 A5A50082 15
0000020C A5A50083 15
00000210 A5A50084 15
00000214 A5A50085 15
00000218 A5A50086 15
0000021C A5A50087 15

/* tb/rv_core_tb.sv */
`default_nettype none

module rv_core_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] RESET_PC   = 32'h0000_0000;
  localparam int          MAX_CYCLES = 5000;
  localparam logic [31:0] END_ADDR   = 32'h0000_03fc;

  logic        clk;
  logic        arst_n;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic        dmem_req;
  logic        dmem_write;
  logic [1:0]  dmem_size;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic [31:0] dmem_rdata;
  logic        dmem_ack_n;

  logic [31:0] pat [0:511];
  logic [31:0] exp_order [$];
  int          prog_len;
  int          check_len;
  int          fails;
  int          tests_ok;
  int          tests_bad;

  rv_core #(
    .RESET_PC (RESET_PC)
  ) dut_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_req   (dmem_req),
    .dmem_write (dmem_write),
    .dmem_size  (dmem_size),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_rdata (dmem_rdata),
    .dmem_ack_n (dmem_ack_n)
  );

  rv_core_mem mem_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_req   (dmem_req),
    .dmem_write (dmem_write),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_rdata (dmem_rdata),
    .dmem_ack_n (dmem_ack_n)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic string test_name(input int t);
    case (t)
      2:       return "alu_immediate";
      3:       return "forwarding";
      4:       return "load_use";
      5:       return "control_flow";
      default: return "store_order";
    endcase
  endfunction

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s: got 0x%08h expected 0x%08h", $time, name, got, exp);
      fails++;
    end
  endtask

  task automatic close_test(input string name, input int fails_at_start);
    if (fails == fails_at_start) begin
      $display("test %s: ok", name);
      tests_ok++;
    end else begin
      $display("test %s: failed", name);
      tests_bad++;
    end
  endtask

  // kind column: low nibble is the test, bit 4 marks an unwritten word
  task automatic check_ram(input int t);
    int          base;
    logic [31:0] addr;
    logic [31:0] kind;
    for (int i = 0; i < check_len; i++) begin
      base = 2 + prog_len + 3 * i;
      addr = pat[base];
      kind = pat[base + 2];
      if (kind[3:0] == t) begin
        compare_word($sformatf("dmem[0x%03h]", addr), mem_i.ram[addr[11:2]], pat[base + 1]);
      end
    end
  endtask

  task automatic check_order();
    int base;
    exp_order.delete();
    for (int i = 0; i < check_len; i++) begin
      base = 2 + prog_len + 3 * i;
      if (!pat[base + 2][4]) begin
        exp_order.push_back(pat[base]);
      end
    end
    if (mem_i.wr_log.size() != exp_order.size()) begin
      $display("store count wrong: %0d stores seen, %0d expected",
               mem_i.wr_log.size(), exp_order.size());
      fails++;
    end else begin
      for (int i = 0; i < exp_order.size(); i++) begin
        compare_word($sformatf("store_addr[%0d]", i), mem_i.wr_log[i], exp_order[i]);
      end
    end
  endtask

  initial begin
    int  fails_at_start;
    int  cycles;
    bit  done;
    fails     = 0;
    tests_ok  = 0;
    tests_bad = 0;
    arst_n    = 1'b0;
    // after the memory model has applied its fill
    #1;
    $readmemh("tb/rv_core_patterns.hex", pat);
    prog_len  = pat[0];
    check_len = pat[1];
    for (int i = 0; i < prog_len; i++) begin
      mem_i.rom[i] = pat[2 + i];
    end

    fails_at_start = fails;
    repeat (2) begin
      @(posedge clk);
      #1;
      compare_word("imem_addr", imem_addr, RESET_PC);
      compare_word("dmem_req", {31'b0, dmem_req}, 32'h0);
    end
    arst_n = 1'b1;
    close_test("reset", fails_at_start);

    // run until the closing store lands
    // every request on the way must be a word access
    fails_at_start = fails;
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < MAX_CYCLES) begin
      @(posedge clk);
      #1;
      cycles++;
      if (dmem_req) begin
        compare_word("dmem_size", {30'b0, dmem_size}, 32'h0000_0002);
      end
      if (mem_i.wr_log.size() > 0 && mem_i.wr_log[$] == END_ADDR) begin
        done = 1'b1;
      end
    end
    if (!done) begin
      $display("timeout: program did not store to 0x3fc within %0d cycles", MAX_CYCLES);
      $display("Verification failed");
      $finish;
    end else begin
      close_test("word_size", fails_at_start);
      for (int t = 2; t <= 6; t++) begin
        fails_at_start = fails;
        check_ram(t);
        if (t == 6) begin
          check_order();
        end
        close_test(test_name(t), fails_at_start);
      end
      $display("tests passed %0d, failed %0d", tests_ok, tests_bad);
      if (fails == 0 && tests_bad == 0) begin
        $display("Verification passed");
      end else begin
        $display("Verification failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* tb/rv_core_mem.sv */
`default_nettype none

module rv_core_mem (
  input  logic        clk,
  input  logic        arst_n,
  input  logic [31:0] imem_addr,
  output logic [31:0] imem_data,
  input  logic        dmem_req,
  input  logic        dmem_write,
  input  logic [31:0] dmem_addr,
  input  logic [31:0] dmem_wdata,
  output logic [31:0] dmem_rdata,
  output logic        dmem_ack_n
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0] rom [0:1023];
  logic [31:0] ram [0:1023];
  // write addresses in the order the stores completed
  logic [31:0] wr_log [$];
  integer      seed;
  int          delay;
  logic        pending;

  assign imem_data = rom[imem_addr[11:2]];

  initial begin
    seed       = 32'h3e9d;
    pending    = 1'b0;
    delay      = 0;
    dmem_ack_n = 1'b1;
    dmem_rdata = '0;
    // rom fill is addi x0 with the word index, ram fill tags its index
    for (int i = 0; i < 1024; i++) begin
      rom[i] = {2'b00, i[9:0], 20'h00013};
      ram[i] = {16'ha5a5, 6'b000000, i[9:0]};
    end
    forever begin
      @(posedge clk);
      #1;
      // a low acknowledge ended the access at this edge
      if (!dmem_ack_n) begin
        dmem_ack_n = 1'b1;
        pending    = 1'b0;
      end
      if (arst_n && dmem_req) begin
        if (!pending) begin
          pending = 1'b1;
          delay   = $unsigned($random(seed)) % 4;
        end
        if (delay == 0) begin
          if (dmem_write) begin
            ram[dmem_addr[11:2]] = dmem_wdata;
            wr_log.push_back(dmem_addr);
          end else begin
            dmem_rdata = ram[dmem_addr[11:2]];
          end
          dmem_ack_n = 1'b0;
        end else begin
          delay--;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/rv_core.sv */
`default_nettype none

module rv_core import rv_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic            clk,
  input  logic            arst_n,
  output logic [XLEN-1:0] imem_addr,
  input  logic [XLEN-1:0] imem_data,
  output logic            dmem_req,
  output logic            dmem_write,
  output logic [1:0]      dmem_size,
  output logic [XLEN-1:0] dmem_addr,
  output logic [XLEN-1:0] dmem_wdata,
  input  logic [XLEN-1:0] dmem_rdata,
  input  logic            dmem_ack_n
);

  logic [XLEN-1:0] inst_d;
  logic            branch_taken;
  imm_src_e        imm_src;
  ctrl_e_s         ctrl_e;
  ctrl_m_s         ctrl_m;
  ctrl_w_s         ctrl_w;
  hz_regs_s        regs;
  hz_ctrl_s        hz;

  // request lines come from the memory-stage bundle
  assign dmem_req   = ctrl_m.mem_req;
  assign dmem_write = ctrl_m.mem_write;
  assign dmem_size  = SIZE_WORD;

  rv_datapath #(
    .RESET_PC (RESET_PC)
  ) datapath_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .imem_data    (imem_data),
    .dmem_rdata   (dmem_rdata),
    .imm_src      (imm_src),
    .ctrl_e       (ctrl_e),
    .ctrl_m       (ctrl_m),
    .ctrl_w       (ctrl_w),
    .hz           (hz),
    .imem_addr    (imem_addr),
    .dmem_addr    (dmem_addr),
    .dmem_wdata   (dmem_wdata),
    .inst_d       (inst_d),
    .branch_taken (branch_taken),
    .regs         (regs)
  );

  rv_controller controller_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .inst         (inst_d),
    .branch_taken (branch_taken),
    .hz           (hz),
    .imm_src      (imm_src),
    .ctrl_e       (ctrl_e),
    .ctrl_m       (ctrl_m),
    .ctrl_w       (ctrl_w)
  );

  rv_hazard hazard_i (
    .regs         (regs),
    .ctrl_e       (ctrl_e),
    .ctrl_m       (ctrl_m),
    .ctrl_w       (ctrl_w),
    .branch_taken (branch_taken),
    .dmem_req     (dmem_req),
    .dmem_ack_n   (dmem_ack_n),
    .hz           (hz)
  );

endmodule

`default_nettype wire

/* hdl/rv_datapath.sv */
`default_nettype none

module rv_datapath import rv_pkg::*; #(
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic            clk,
  input  logic            arst_n,
  input  logic [XLEN-1:0] imem_data,
  input  logic [XLEN-1:0] dmem_rdata,
  input  imm_src_e        imm_src,
  input  ctrl_e_s         ctrl_e,
  input  ctrl_m_s         ctrl_m,
  input  ctrl_w_s         ctrl_w,
  input  hz_ctrl_s        hz,
  output logic [XLEN-1:0] imem_addr,
  output logic [XLEN-1:0] dmem_addr,
  output logic [XLEN-1:0] dmem_wdata,
  output logic [XLEN-1:0] inst_d,
  output logic            branch_taken,
  output hz_regs_s        regs
);

  logic [XLEN-1:0]   pc_f, pc_plus4_f, pc_d, pc_plus4_d;
  logic [XLEN-1:0]   imm_d, rdata1_d, rdata2_d;
  logic [XLEN-1:0]   rdata1_e, rdata2_e, imm_e, pc_e, pc_plus4_e;
  logic [XLEN-1:0]   src_a_e, store_data_e, src_b_e, alu_result_e, target_e;
  logic              zero_e, lt_e, ltu_e;
  logic [XLEN-1:0]   alu_m, wdata_m, pc_plus4_m;
  logic [XLEN-1:0]   alu_w, rdata_w, pc_plus4_w, result_w;
  logic [REG_AW-1:0] rs1_e, rs2_e, rd_e, rd_m, rd_w;

  function automatic logic [XLEN-1:0] fwd_mux(
    input fwd_sel_e        sel,
    input logic [XLEN-1:0] reg_val,
    input logic [XLEN-1:0] m_val,
    input logic [XLEN-1:0] w_val
  );
    case (sel)
      fwd_from_m: return m_val;
      fwd_from_w: return w_val;
      default:    return reg_val;
    endcase
  endfunction

  // fetch
  assign pc_plus4_f = pc_f + XLEN'(4);
  assign imem_addr  = pc_f;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_f <= RESET_PC;
    end else if (!hz.f_stall) begin
      pc_f <= branch_taken ? target_e : pc_plus4_f;
    end
  end

  // all-zero word decodes as a bubble
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      inst_d <= '0;
    end else if (!hz.d_stall) begin
      inst_d <= hz.d_flush ? '0 : imem_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!hz.d_stall) begin
      pc_d       <= pc_f;
      pc_plus4_d <= pc_plus4_f;
    end
  end

  // decode
  always_comb begin
    case (imm_src)
      imm_s:   imm_d = {{20{inst_d[31]}}, inst_d[31:25], inst_d[11:7]};
      imm_b:   imm_d = {{19{inst_d[31]}}, inst_d[31], inst_d[7], inst_d[30:25],
                        inst_d[11:8], 1'b0};
      imm_u:   imm_d = {inst_d[31:12], 12'b0};
      imm_j:   imm_d = {{11{inst_d[31]}}, inst_d[31], inst_d[19:12], inst_d[20],
                        inst_d[30:21], 1'b0};
      default: imm_d = {{20{inst_d[31]}}, inst_d[31:20]};
    endcase
  end

  rv_regfile regfile_i (
    .clk    (clk),
    .arst_n (arst_n),
    .rs1    (inst_d[19:15]),
    .rs2    (inst_d[24:20]),
    .rd     (rd_w),
    .wdata  (result_w),
    .we     (ctrl_w.reg_write),
    .rdata1 (rdata1_d),
    .rdata2 (rdata2_d)
  );

  // register numbers drive hazard checks, so they get a reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rs1_e <= '0;
      rs2_e <= '0;
      rd_e  <= '0;
      rd_m  <= '0;
      rd_w  <= '0;
    end else if (!hz.m_stall) begin
      rs1_e <= inst_d[19:15];
      rs2_e <= inst_d[24:20];
      rd_e  <= inst_d[11:7];
      rd_m  <= rd_e;
      rd_w  <= rd_m;
    end
  end

  always_ff @(posedge clk) begin
    if (!hz.m_stall) begin
      rdata1_e   <= rdata1_d;
      rdata2_e   <= rdata2_d;
      imm_e      <= imm_d;
      pc_e       <= pc_d;
      pc_plus4_e <= pc_plus4_d;
    end
  end

  // execute
  assign src_a_e      = fwd_mux(hz.fwd_a, rdata1_e, alu_m, result_w);
  assign store_data_e = fwd_mux(hz.fwd_b, rdata2_e, alu_m, result_w);
  assign src_b_e      = ctrl_e.alu_src_imm ? imm_e : store_data_e;
  assign target_e     = pc_e + imm_e;

  rv_alu alu_i (
    .a      (src_a_e),
    .b      (src_b_e),
    .op     (ctrl_e.alu_op),
    .result (alu_result_e),
    .zero   (zero_e),
    .lt     (lt_e),
    .ltu    (ltu_e)
  );

  always_comb begin
    case (ctrl_e.branch)
      br_eq:   branch_taken = zero_e;
      br_ne:   branch_taken = !zero_e;
      br_lt:   branch_taken = lt_e;
      br_ge:   branch_taken = !lt_e;
      br_ltu:  branch_taken = ltu_e;
      br_geu:  branch_taken = !ltu_e;
      br_jump: branch_taken = 1'b1;
      default: branch_taken = 1'b0;
    endcase
  end

  // memory and writeback
  always_ff @(posedge clk) begin
    if (!hz.m_stall) begin
      alu_m      <= alu_result_e;
      wdata_m    <= store_data_e;
      pc_plus4_m <= pc_plus4_e;
      alu_w      <= alu_m;
      pc_plus4_w <= pc_plus4_m;
      // load data only taken when the acknowledge ends the read
      if (ctrl_m.mem_req && !ctrl_m.mem_write) begin
        rdata_w <= dmem_rdata;
      end
    end
  end

  assign dmem_addr  = alu_m;
  assign dmem_wdata = wdata_m;

  always_comb begin
    case (ctrl_w.result_src)
      res_mem:      result_w = rdata_w;
      res_pc_plus4: result_w = pc_plus4_w;
      default:      result_w = alu_w;
    endcase
  end

  assign regs = '{
    d_rs1: inst_d[19:15],
    d_rs2: inst_d[24:20],
    e_rs1: rs1_e,
    e_rs2: rs2_e,
    e_rd:  rd_e,
    m_rd:  rd_m,
    w_rd:  rd_w
  };

  a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
    pc_f[1:0] == 2'b00);

endmodule

`default_nettype wire

/* hdl/rv_hazard.sv */
`default_nettype none

module rv_hazard import rv_pkg::*; (
  input  hz_regs_s regs,
  input  ctrl_e_s  ctrl_e,
  input  ctrl_m_s  ctrl_m,
  input  ctrl_w_s  ctrl_w,
  input  logic     branch_taken,
  input  logic     dmem_req,
  input  logic     dmem_ack_n,
  output hz_ctrl_s hz
);

  logic mem_wait;
  logic lw_stall;

  // youngest producer wins, x0 never forwards
  function automatic fwd_sel_e pick_fwd(
    input logic [REG_AW-1:0] rs,
    input logic [REG_AW-1:0] m_rd,
    input logic              m_we,
    input logic [REG_AW-1:0] w_rd,
    input logic              w_we
  );
    fwd_sel_e sel;
    sel = fwd_reg;
    if (rs != '0 && m_we && m_rd == rs) begin
      sel = fwd_from_m;
    end else if (rs != '0 && w_we && w_rd == rs) begin
      sel = fwd_from_w;
    end
    return sel;
  endfunction

  always_comb begin
    mem_wait = dmem_req && dmem_ack_n;
    // load in execute feeding the instruction in decode
    lw_stall = ctrl_e.m.w.reg_write && ctrl_e.m.w.result_src == res_mem &&
               regs.e_rd != '0 &&
               (regs.e_rd == regs.d_rs1 || regs.e_rd == regs.d_rs2);

    hz.fwd_a = pick_fwd(regs.e_rs1, regs.m_rd, ctrl_m.w.reg_write,
                        regs.w_rd, ctrl_w.reg_write);
    hz.fwd_b = pick_fwd(regs.e_rs2, regs.m_rd, ctrl_m.w.reg_write,
                        regs.w_rd, ctrl_w.reg_write);

    // pending data access freezes everything and blocks flushes
    hz.m_stall = mem_wait;
    hz.f_stall = mem_wait || lw_stall;
    hz.d_stall = mem_wait || lw_stall;
    hz.d_flush = !mem_wait && branch_taken;
    hz.e_flush = !mem_wait && (branch_taken || lw_stall);
  end

endmodule

`default_nettype wire

/* hdl/rv_controller.sv */
`default_nettype none

module rv_controller import rv_pkg::*; (
  input  logic            clk,
  input  logic            arst_n,
  input  logic [XLEN-1:0] inst,
  input  logic            branch_taken,
  input  hz_ctrl_s        hz,
  output imm_src_e        imm_src,
  output ctrl_e_s         ctrl_e,
  output ctrl_m_s         ctrl_m,
  output ctrl_w_s         ctrl_w
);

  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;

  logic [6:0] opcode;
  logic [2:0] funct3;
  alu_op_e    arith_op;
  ctrl_e_s    ctrl_d;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];

  // funct3 map shared by register and immediate forms
  // bit 30 picks sub only for register ops, sra for both
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (opcode == op_reg && inst[30]) ? alu_sub : alu_add;
      3'b001:  arith_op = alu_sll;
      3'b010:  arith_op = alu_slt;
      3'b011:  arith_op = alu_sltu;
      3'b100:  arith_op = alu_xor;
      3'b101:  arith_op = inst[30] ? alu_sra : alu_srl;
      3'b110:  arith_op = alu_or;
      default: arith_op = alu_and;
    endcase
  end

  // anything not listed stays an all-zero bubble
  always_comb begin
    ctrl_d  = '0;
    imm_src = imm_i;
    case (opcode)
      op_reg: begin
        ctrl_d.alu_op        = arith_op;
        ctrl_d.m.w.reg_write = 1'b1;
      end
      op_imm: begin
        ctrl_d.alu_op        = arith_op;
        ctrl_d.alu_src_imm   = 1'b1;
        ctrl_d.m.w.reg_write = 1'b1;
      end
      op_lui: begin
        imm_src              = imm_u;
        ctrl_d.alu_op        = alu_pass_b;
        ctrl_d.alu_src_imm   = 1'b1;
        ctrl_d.m.w.reg_write = 1'b1;
      end
      op_load: begin
        if (funct3 == 3'b010) begin
          ctrl_d.alu_src_imm    = 1'b1;
          ctrl_d.m.mem_req      = 1'b1;
          ctrl_d.m.w.reg_write  = 1'b1;
          ctrl_d.m.w.result_src = res_mem;
        end
      end
      op_store: begin
        imm_src = imm_s;
        if (funct3 == 3'b010) begin
          ctrl_d.alu_src_imm = 1'b1;
          ctrl_d.m.mem_req   = 1'b1;
          ctrl_d.m.mem_write = 1'b1;
        end
      end
      op_branch: begin
        imm_src       = imm_b;
        ctrl_d.alu_op = alu_sub;
        case (funct3)
          3'b000:  ctrl_d.branch = br_eq;
          3'b001:  ctrl_d.branch = br_ne;
          3'b100:  ctrl_d.branch = br_lt;
          3'b101:  ctrl_d.branch = br_ge;
          3'b110:  ctrl_d.branch = br_ltu;
          3'b111:  ctrl_d.branch = br_geu;
          default: ctrl_d.branch = br_none;
        endcase
      end
      op_jal: begin
        imm_src               = imm_j;
        ctrl_d.branch         = br_jump;
        ctrl_d.m.w.reg_write  = 1'b1;
        ctrl_d.m.w.result_src = res_pc_plus4;
      end
      default: begin
      end
    endcase
  end

  // E/M/W control pipeline, frozen while memory is busy
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ctrl_e <= '0;
      ctrl_m <= '0;
      ctrl_w <= '0;
    end else if (!hz.m_stall) begin
      if (hz.e_flush) begin
        ctrl_e <= '0;
      end else begin
        ctrl_e <= ctrl_d;
      end
      ctrl_m <= ctrl_e.m;
      ctrl_w <= ctrl_m.w;
    end
  end

  a_store_is_request: assert property (@(posedge clk) disable iff (!arst_n)
    ctrl_m.mem_write |-> ctrl_m.mem_req);

  // a taken branch leaves a bubble in execute
  a_branch_flush: assert property (@(posedge clk) disable iff (!arst_n)
    (branch_taken && !hz.m_stall) |=> ctrl_e == '0);

endmodule

`default_nettype wire

/* hdl/rv_regfile.sv */
`default_nettype none

module rv_regfile import rv_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  logic [REG_AW-1:0] rs1,
  input  logic [REG_AW-1:0] rs2,
  input  logic [REG_AW-1:0] rd,
  input  logic [XLEN-1:0]   wdata,
  input  logic              we,
  output logic [XLEN-1:0]   rdata1,
  output logic [XLEN-1:0]   rdata2
);

  // x0 has no storage
  logic [XLEN-1:0] regs [1:2**REG_AW-1];

  always_ff @(posedge clk) begin
    if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // write-through, decode sees the value being written back
  always_comb begin
    if (rs1 == '0) begin
      rdata1 = '0;
    end else if (we && rd == rs1) begin
      rdata1 = wdata;
    end else begin
      rdata1 = regs[rs1];
    end
  end

  always_comb begin
    if (rs2 == '0) begin
      rdata2 = '0;
    end else if (we && rd == rs2) begin
      rdata2 = wdata;
    end else begin
      rdata2 = regs[rs2];
    end
  end

  // a written register reads back its new value one cycle later
  a_write_reads_back: assert property (@(posedge clk) disable iff (!arst_n)
    (we && rd != '0) ##1 (rs1 == $past(rd) && !(we && rd == rs1))
      |-> rdata1 == $past(wdata));

endmodule

`default_nettype wire

/* hdl/rv_alu.sv */
`default_nettype none

module rv_alu import rv_pkg::*; (
  input  logic [XLEN-1:0] a,
  input  logic [XLEN-1:0] b,
  input  alu_op_e         op,
  output logic [XLEN-1:0] result,
  output logic            zero,
  output logic            lt,
  output logic            ltu
);

  logic [$clog2(XLEN)-1:0] shamt;

  assign shamt = b[$clog2(XLEN)-1:0];

  // compare flags come straight from the operands
  assign lt  = $signed(a) < $signed(b);
  assign ltu = a < b;

  always_comb begin
    case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_and:    result = a & b;
      alu_or:     result = a | b;
      alu_xor:    result = a ^ b;
      alu_slt:    result = {{(XLEN-1){1'b0}}, lt};
      alu_sltu:   result = {{(XLEN-1){1'b0}}, ltu};
      alu_sll:    result = a << shamt;
      alu_srl:    result = a >> shamt;
      alu_sra:    result = $signed(a) >>> shamt;
      alu_pass_b: result = b;
      default:    result = a + b;
    endcase
  end

  // equality for branches, op is sub there
  assign zero = (result == '0);

endmodule

`default_nettype wire

/* hdl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  localparam int XLEN   = 32;
  localparam int REG_AW = 5;

  // size code on the data port, only word accesses exist
  localparam logic [1:0] SIZE_WORD = 2'b10;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sltu,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_pass_b
  } alu_op_e;

  typedef enum logic [2:0] {
    imm_i,
    imm_s,
    imm_b,
    imm_u,
    imm_j
  } imm_src_e;

  typedef enum logic [1:0] {
    res_alu,
    res_mem,
    res_pc_plus4
  } result_src_e;

  typedef enum logic [2:0] {
    br_none,
    br_eq,
    br_ne,
    br_lt,
    br_ge,
    br_ltu,
    br_geu,
    br_jump
  } branch_e;

  typedef enum logic [1:0] {
    fwd_reg,
    fwd_from_m,
    fwd_from_w
  } fwd_sel_e;

  // control bundles, each stage peels off its own fields
  typedef struct packed {
    logic        reg_write;
    result_src_e result_src;
  } ctrl_w_s;

  typedef struct packed {
    logic    mem_req;
    logic    mem_write;
    ctrl_w_s w;
  } ctrl_m_s;

  typedef struct packed {
    alu_op_e alu_op;
    logic    alu_src_imm;
    branch_e branch;
    ctrl_m_s m;
  } ctrl_e_s;

  // register numbers seen by the hazard unit
  typedef struct packed {
    logic [REG_AW-1:0] d_rs1;
    logic [REG_AW-1:0] d_rs2;
    logic [REG_AW-1:0] e_rs1;
    logic [REG_AW-1:0] e_rs2;
    logic [REG_AW-1:0] e_rd;
    logic [REG_AW-1:0] m_rd;
    logic [REG_AW-1:0] w_rd;
  } hz_regs_s;

  typedef struct packed {
    logic     f_stall;
    logic     d_stall;
    logic     d_flush;
    logic     e_flush;
    logic     m_stall;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
  } hz_ctrl_s;

endpackage

`default_nettype wire
